// File: hw/id_class_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_params.svh"
`include "id_opcodes.svh"

module id_class_decode
    import id_pkg::*;
(
    id_decode_if.class_src dec,
    input  instr_t         instr
);

    opc_t                     opc;
    logic [`ID_OPCLASS_W-1:0] opclass;
    logic                     known;
    logic                     gp_we;

    assign opc     = instr[`ID_OPC_HI:`ID_OPC_LO];
    assign opclass = instr[`ID_OPC_HI:`ID_OPCLASS_LO];

    // Gaps inside a class must not pick up that class's flags
    always_comb begin
        case (opc)
            `OPC_MOVur, `OPC_ADDur, `OPC_SUBur, `OPC_ANDur, `OPC_ORur, `OPC_CMPur,
            `OPC_MOVui, `OPC_ADDui, `OPC_CMPui,
            `OPC_ADDsr, `OPC_SUBsr, `OPC_MOVsi, `OPC_ADDsi,
            `OPC_LDur, `OPC_STur,
            `OPC_JCCui, `OPC_BCCso, `OPC_BALso, `OPC_MCCur: known = 1'b1;
            default: known = 1'b0;
        endcase
    end

    always_comb begin
        case (opc)
            `OPC_MOVur, `OPC_ADDur, `OPC_SUBur, `OPC_ANDur, `OPC_ORur,
            `OPC_MOVui, `OPC_ADDui,
            `OPC_ADDsr, `OPC_SUBsr, `OPC_MOVsi, `OPC_ADDsi,
            `OPC_LDur, `OPC_MCCur: gp_we = 1'b1;
            default: gp_we = 1'b0;
        endcase
    end

    assign dec.opc = opc;

    // Branch offsets are signed too
    assign dec.sgn_en = known &&
        ((opclass == `OPCLASS_SREG) || (opclass == `OPCLASS_SIMM) ||
         (opc == `OPC_BCCso) || (opc == `OPC_BALso));

    assign dec.imm_en = known &&
        ((opclass == `OPCLASS_UIMM) || (opclass == `OPCLASS_SIMM) ||
         (opc == `OPC_JCCui) || (opc == `OPC_BCCso) || (opc == `OPC_BALso));

    assign dec.tgt_gp_we = gp_we;

    // Compares name a target they never write
    assign dec.has_tgt_gp = gp_we || (opc == `OPC_CMPur) || (opc == `OPC_CMPui);

    assign dec.has_src_gp = known &&
        ((opclass == `OPCLASS_UREG) || (opc == `OPC_ADDsr) || (opc == `OPC_SUBsr) ||
         (opc == `OPC_STur) || (opc == `OPC_MCCur));

    // Every control op tests the flags
    assign dec.reads_flags = known && (opclass == `OPCLASS_CTRL);

endmodule

`default_nettype wire

// File: hw/id_decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface id_decode_if
    import id_pkg::*;
();

    // Class flags
    opc_t    opc;
    logic    sgn_en;
    logic    imm_en;
    logic    tgt_gp_we;
    logic    has_tgt_gp;
    logic    has_src_gp;
    logic    reads_flags;

    // Extracted fields
    gp_idx_t tgt_gp;
    gp_idx_t src_gp;
    logic    has_src_ar;
    ar_idx_t src_ar;
    logic    has_tgt_ar;
    ar_idx_t tgt_ar;
    cc_t     cc;
    imm12_t  imm12;
    imm16_t  imm16;

    modport class_src (
        output opc, sgn_en, imm_en, tgt_gp_we, has_tgt_gp, has_src_gp, reads_flags
    );

    modport field_src (
        input  opc, imm_en, has_tgt_gp, has_src_gp,
        output tgt_gp, src_gp, has_src_ar, src_ar, has_tgt_ar, tgt_ar, cc, imm12, imm16
    );

    // has_tgt_gp only steers field extraction
    modport sink (
        input opc, sgn_en, imm_en, tgt_gp_we, has_src_gp, reads_flags,
              tgt_gp, src_gp, has_src_ar, src_ar, has_tgt_ar, tgt_ar, cc, imm12, imm16
    );

endinterface

`default_nettype wire

// File: hw/id_field_extract.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_params.svh"
`include "id_opcodes.svh"

module id_field_extract
    import id_pkg::*;
(
    id_decode_if.field_src dec,
    input  instr_t         instr
);

    logic is_load;
    logic is_store;
    logic is_bal;

    assign is_load  = (dec.opc == `OPC_LDur);
    assign is_store = (dec.opc == `OPC_STur);
    assign is_bal   = (dec.opc == `OPC_BALso);

    assign dec.tgt_gp = dec.has_tgt_gp ? instr[`ID_TGT_GP_HI:`ID_TGT_GP_LO] : '0;

    always_comb begin
        if (!dec.has_src_gp) begin
            dec.src_gp = '0;
        end else if (is_store) begin
            dec.src_gp = instr[`ID_ST_SRC_GP_HI:`ID_ST_SRC_GP_LO];
        end else begin
            dec.src_gp = instr[`ID_SRC_GP_HI:`ID_SRC_GP_LO];
        end
    end

    // Load reads through an AR base, store writes through one
    assign dec.has_src_ar = is_load;
    assign dec.src_ar     = is_load ? instr[`ID_SRC_AR_HI:`ID_SRC_AR_LO] : '0;
    assign dec.has_tgt_ar = is_store;
    assign dec.tgt_ar     = is_store ? instr[`ID_TGT_AR_HI:`ID_TGT_AR_LO] : '0;

    always_comb begin
        case (dec.opc)
            `OPC_JCCui, `OPC_BCCso: dec.cc = instr[`ID_CC_BR_HI:`ID_CC_BR_LO];
            `OPC_MCCur:             dec.cc = instr[`ID_CC_MCC_HI:`ID_CC_MCC_LO];
            default:                dec.cc = '0;
        endcase
    end

    // BALso is the only immediate op with the wide form
    assign dec.imm12 = (dec.imm_en && !is_bal) ? instr[`ID_IMM12_W-1:0] : '0;
    assign dec.imm16 = is_bal ? instr[`ID_IMM16_W-1:0] : '0;

endmodule

`default_nettype wire

// File: hw/id_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_pipe_reg
    import id_pkg::*;
(
    input  logic      iw_clk,
    input  logic      iw_rst,
    input  logic      stall,
    input  logic      flush,
    input  pc_t       pc_in,
    input  instr_t    instr_in,
    id_decode_if.sink dec,
    output pc_t       pc,
    output instr_t    instr,
    output opc_t      opc,
    output logic      sgn_en,
    output logic      imm_en,
    output logic      tgt_gp_we,
    output logic      has_src_gp,
    output logic      reads_flags,
    output gp_idx_t   tgt_gp,
    output gp_idx_t   src_gp,
    output logic      has_src_ar,
    output ar_idx_t   src_ar,
    output logic      has_tgt_ar,
    output ar_idx_t   tgt_ar,
    output cc_t       cc,
    output imm12_t    imm12,
    output imm16_t    imm16
);

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pc          <= '0;
            instr       <= '0;
            opc         <= '0;
            sgn_en      <= 1'b0;
            imm_en      <= 1'b0;
            tgt_gp_we   <= 1'b0;
            has_src_gp  <= 1'b0;
            reads_flags <= 1'b0;
            tgt_gp      <= '0;
            src_gp      <= '0;
            has_src_ar  <= 1'b0;
            src_ar      <= '0;
            has_tgt_ar  <= 1'b0;
            tgt_ar      <= '0;
            cc          <= '0;
            imm12       <= '0;
            imm16       <= '0;
        end else if (flush || !stall) begin
            // Flush beats stall and loads a bubble
            pc          <= flush ? '0 : pc_in;
            instr       <= flush ? '0 : instr_in;
            opc         <= flush ? '0 : dec.opc;
            sgn_en      <= !flush && dec.sgn_en;
            imm_en      <= !flush && dec.imm_en;
            tgt_gp_we   <= !flush && dec.tgt_gp_we;
            has_src_gp  <= !flush && dec.has_src_gp;
            reads_flags <= !flush && dec.reads_flags;
            tgt_gp      <= flush ? '0 : dec.tgt_gp;
            src_gp      <= flush ? '0 : dec.src_gp;
            has_src_ar  <= !flush && dec.has_src_ar;
            src_ar      <= flush ? '0 : dec.src_ar;
            has_tgt_ar  <= !flush && dec.has_tgt_ar;
            tgt_ar      <= flush ? '0 : dec.tgt_ar;
            cc          <= flush ? '0 : dec.cc;
            imm12       <= flush ? '0 : dec.imm12;
            imm16       <= flush ? '0 : dec.imm16;
        end
    end

endmodule

`default_nettype wire

// File: hw/id_pkg.sv
`default_nettype none

`include "id_params.svh"

package id_pkg;

    typedef logic [`ID_ADDR_W-1:0]  pc_t;
    typedef logic [`ID_DATA_W-1:0]  instr_t;
    typedef logic [`ID_OPC_W-1:0]   opc_t;
    typedef logic [`ID_CC_W-1:0]    cc_t;

    // Register file indices
    typedef logic [`ID_GP_W-1:0]    gp_idx_t;
    typedef logic [`ID_AR_W-1:0]    ar_idx_t;

    // Zero-extended immediates, sign handled downstream via sgn_en
    typedef logic [`ID_IMM12_W-1:0] imm12_t;
    typedef logic [`ID_IMM16_W-1:0] imm16_t;

endpackage

`default_nettype wire

// File: hw/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage
    import id_pkg::*;
(
    input  logic    iw_clk,
    input  logic    iw_rst,
    input  pc_t     pc,
    input  instr_t  instr,
    input  logic    stall,
    input  logic    flush,
    output pc_t     pc_out,
    output instr_t  instr_out,
    output opc_t    opc,
    output logic    sgn_en,
    output logic    imm_en,
    output logic    tgt_gp_we,
    output logic    has_src_gp,
    output logic    reads_flags,
    output gp_idx_t tgt_gp,
    output gp_idx_t src_gp,
    output logic    has_src_ar,
    output ar_idx_t src_ar,
    output logic    has_tgt_ar,
    output ar_idx_t tgt_ar,
    output cc_t     cc,
    output imm12_t  imm12,
    output imm16_t  imm16
);

    id_decode_if dec ();

    // Combinational decode of the fetched word
    id_class_decode i_class_decode (
        .dec   (dec.class_src),
        .instr (instr)
    );

    id_field_extract i_field_extract (
        .dec   (dec.field_src),
        .instr (instr)
    );

    id_pipe_reg i_pipe_reg (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .stall       (stall),
        .flush       (flush),
        .pc_in       (pc),
        .instr_in    (instr),
        .dec         (dec.sink),
        .pc          (pc_out),
        .instr       (instr_out),
        .opc         (opc),
        .sgn_en      (sgn_en),
        .imm_en      (imm_en),
        .tgt_gp_we   (tgt_gp_we),
        .has_src_gp  (has_src_gp),
        .reads_flags (reads_flags),
        .tgt_gp      (tgt_gp),
        .src_gp      (src_gp),
        .has_src_ar  (has_src_ar),
        .src_ar      (src_ar),
        .has_tgt_ar  (has_tgt_ar),
        .tgt_ar      (tgt_ar),
        .cc          (cc),
        .imm12       (imm12),
        .imm16       (imm16)
    );

endmodule

`default_nettype wire

// File: include/id_opcodes.svh
`ifndef ID_OPCODES_SVH
`define ID_OPCODES_SVH

// Opclass values, upper nibble of the opcode
`define OPCLASS_UREG    4'h0
`define OPCLASS_UIMM    4'h1
`define OPCLASS_SREG    4'h2
`define OPCLASS_SIMM    4'h3
`define OPCLASS_CTRL    4'h7

// Class 0, unsigned register
`define OPC_MOVur       8'h00
`define OPC_ADDur       8'h01
`define OPC_SUBur       8'h02
`define OPC_ANDur       8'h03
`define OPC_ORur        8'h04
`define OPC_CMPur       8'h05

// Class 1, unsigned 12-bit immediate
`define OPC_MOVui       8'h10
`define OPC_ADDui       8'h11
`define OPC_CMPui       8'h12

// Class 2 and 3, signed
`define OPC_ADDsr       8'h20
`define OPC_SUBsr       8'h21
`define OPC_MOVsi       8'h30
`define OPC_ADDsi       8'h31

// Class 4, memory through an AR base
`define OPC_LDur        8'h40
`define OPC_STur        8'h41

// Class 7, control flow
`define OPC_JCCui       8'h70
`define OPC_BCCso       8'h71
`define OPC_BALso       8'h72
`define OPC_MCCur       8'h73

`endif

// File: include/id_params.svh
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

// Datapath widths
`define ID_DATA_W       24
`define ID_ADDR_W       16
`define ID_OPC_W        8
`define ID_OPCLASS_W    4
`define ID_CC_W         4
`define ID_GP_W         4
`define ID_AR_W         2
`define ID_IMM12_W      12
`define ID_IMM16_W      16

// Opcode and opclass positions
`define ID_OPC_HI       23
`define ID_OPC_LO       16
`define ID_OPCLASS_LO   20

// Register fields
`define ID_TGT_GP_HI    15
`define ID_TGT_GP_LO    12
`define ID_SRC_GP_HI    11
`define ID_SRC_GP_LO    8
// Stores move the GP source up to make room for the AR base
`define ID_ST_SRC_GP_HI 13
`define ID_ST_SRC_GP_LO 10
`define ID_SRC_AR_HI    11
`define ID_SRC_AR_LO    10
`define ID_TGT_AR_HI    15
`define ID_TGT_AR_LO    14

// Condition codes
`define ID_CC_BR_HI     15
`define ID_CC_BR_LO     12
`define ID_CC_MCC_HI    7
`define ID_CC_MCC_LO    4

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the ID stage testbench with Verilator

LOG=sim.log

verilator --binary --timescale 1ns/1ps -f tb.f --top-module tb_id_stage -o tb_id_stage
if [ $? -ne 0 ]; then
    echo "Verilator build did not complete"
    exit 1
fi

./obj_dir/tb_id_stage > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q 'All tests passed!' "$LOG"; then
    exit 0
fi
exit 1

// File: tb.f
+incdir+include
hw/id_pkg.sv
hw/id_decode_if.sv
hw/id_class_decode.sv
hw/id_field_extract.sv
hw/id_pipe_reg.sv
hw/id_stage.sv
testbench/id_checker.sv
testbench/tb_id_stage.sv

// File: testbench/id_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_opcodes.svh"

module id_checker
    import id_pkg::*;
(
    input  logic    iw_clk,
    input  logic    iw_rst,
    input  pc_t     pc,
    input  instr_t  instr,
    input  logic    stall,
    input  logic    flush,
    input  pc_t     pc_out,
    input  instr_t  instr_out,
    input  opc_t    opc,
    input  logic    sgn_en,
    input  logic    imm_en,
    input  logic    tgt_gp_we,
    input  logic    has_src_gp,
    input  logic    reads_flags,
    input  gp_idx_t tgt_gp,
    input  gp_idx_t src_gp,
    input  logic    has_src_ar,
    input  ar_idx_t src_ar,
    input  logic    has_tgt_ar,
    input  ar_idx_t tgt_ar,
    input  cc_t     cc,
    input  imm12_t  imm12,
    input  imm16_t  imm16,
    output int      error_count,
    output int      check_count
);

    typedef struct packed {
        pc_t     pc;
        instr_t  instr;
        opc_t    opc;
        logic    sgn_en;
        logic    imm_en;
        logic    tgt_gp_we;
        logic    has_src_gp;
        logic    reads_flags;
        gp_idx_t tgt_gp;
        gp_idx_t src_gp;
        logic    has_src_ar;
        ar_idx_t src_ar;
        logic    has_tgt_ar;
        ar_idx_t tgt_ar;
        cc_t     cc;
        imm12_t  imm12;
        imm16_t  imm16;
    } bundle_t;

    bundle_t exp_q;
    string   kind = "reset";
    int      errors = 0;
    int      checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    // Expected bundle for one fetched word, built opcode by opcode
    function automatic bundle_t decode_ref(input pc_t p, input instr_t w);
        bundle_t b;
        logic    tgt_named;
        b = '0;
        tgt_named = 1'b0;
        b.pc = p;
        b.instr = w;
        b.opc = w[23:16];
        case (w[23:16])
            `OPC_MOVur, `OPC_ADDur, `OPC_SUBur, `OPC_ANDur, `OPC_ORur: begin
                b.tgt_gp_we = 1'b1;
                b.has_src_gp = 1'b1;
            end
            `OPC_CMPur: begin
                tgt_named = 1'b1;
                b.has_src_gp = 1'b1;
            end
            `OPC_MOVui, `OPC_ADDui: begin
                b.tgt_gp_we = 1'b1;
                b.imm_en = 1'b1;
                b.imm12 = w[11:0];
            end
            `OPC_CMPui: begin
                tgt_named = 1'b1;
                b.imm_en = 1'b1;
                b.imm12 = w[11:0];
            end
            `OPC_ADDsr, `OPC_SUBsr: begin
                b.sgn_en = 1'b1;
                b.tgt_gp_we = 1'b1;
                b.has_src_gp = 1'b1;
            end
            `OPC_MOVsi, `OPC_ADDsi: begin
                b.sgn_en = 1'b1;
                b.imm_en = 1'b1;
                b.tgt_gp_we = 1'b1;
                b.imm12 = w[11:0];
            end
            `OPC_LDur: begin
                b.tgt_gp_we = 1'b1;
                b.has_src_ar = 1'b1;
                b.src_ar = w[11:10];
            end
            `OPC_STur: begin
                b.has_src_gp = 1'b1;
                b.has_tgt_ar = 1'b1;
                b.tgt_ar = w[15:14];
            end
            `OPC_JCCui, `OPC_BCCso: begin
                b.sgn_en = (w[23:16] == `OPC_BCCso);
                b.imm_en = 1'b1;
                b.reads_flags = 1'b1;
                b.cc = w[15:12];
                b.imm12 = w[11:0];
            end
            `OPC_BALso: begin
                b.sgn_en = 1'b1;
                b.imm_en = 1'b1;
                b.reads_flags = 1'b1;
                b.imm16 = w[15:0];
            end
            `OPC_MCCur: begin
                b.tgt_gp_we = 1'b1;
                b.has_src_gp = 1'b1;
                b.reads_flags = 1'b1;
                b.cc = w[7:4];
            end
            default: begin
            end
        endcase
        if (b.tgt_gp_we || tgt_named) begin
            b.tgt_gp = w[15:12];
        end
        // Store source sits two bits higher
        if (b.has_src_gp) begin
            b.src_gp = (w[23:16] == `OPC_STur) ? w[13:10] : w[11:8];
        end
        return b;
    endfunction

    task automatic check_field(input string name, input logic [23:0] exp,
                               input logic [23:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s.%s at %0t: expected %0h, actual %0h",
                     kind, name, $time, exp, act);
        end
    endtask

    // Reset, then flush, then stall, then load
    always @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            exp_q = '0;
            kind = "reset";
        end else if (flush) begin
            exp_q = '0;
            kind = "flush";
        end else if (stall) begin
            kind = "stall";
        end else begin
            exp_q = decode_ref(pc, instr);
            kind = "decode";
        end
    end

    // Outputs settled half a cycle after the edge
    always @(negedge iw_clk) begin
        check_field("pc", 24'(exp_q.pc), 24'(pc_out));
        check_field("instr", exp_q.instr, instr_out);
        check_field("opc", 24'(exp_q.opc), 24'(opc));
        check_field("sgn_en", 24'(exp_q.sgn_en), 24'(sgn_en));
        check_field("imm_en", 24'(exp_q.imm_en), 24'(imm_en));
        check_field("tgt_gp_we", 24'(exp_q.tgt_gp_we), 24'(tgt_gp_we));
        check_field("has_src_gp", 24'(exp_q.has_src_gp), 24'(has_src_gp));
        check_field("reads_flags", 24'(exp_q.reads_flags), 24'(reads_flags));
        check_field("tgt_gp", 24'(exp_q.tgt_gp), 24'(tgt_gp));
        check_field("src_gp", 24'(exp_q.src_gp), 24'(src_gp));
        check_field("has_src_ar", 24'(exp_q.has_src_ar), 24'(has_src_ar));
        check_field("src_ar", 24'(exp_q.src_ar), 24'(src_ar));
        check_field("has_tgt_ar", 24'(exp_q.has_tgt_ar), 24'(has_tgt_ar));
        check_field("tgt_ar", 24'(exp_q.tgt_ar), 24'(tgt_ar));
        check_field("cc", 24'(exp_q.cc), 24'(cc));
        check_field("imm12", 24'(exp_q.imm12), 24'(imm12));
        check_field("imm16", 24'(exp_q.imm16), 24'(imm16));
    end

endmodule

`default_nettype wire

// File: testbench/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_opcodes.svh"

module tb_id_stage
    import id_pkg::*;
();

    localparam int NUM_CYCLES    = 2000;
    localparam int DRAIN_TIMEOUT = 20;

    localparam opc_t OPCODES [19] = '{
        `OPC_MOVur, `OPC_ADDur, `OPC_SUBur, `OPC_ANDur, `OPC_ORur, `OPC_CMPur,
        `OPC_MOVui, `OPC_ADDui, `OPC_CMPui,
        `OPC_ADDsr, `OPC_SUBsr, `OPC_MOVsi, `OPC_ADDsi,
        `OPC_LDur, `OPC_STur,
        `OPC_JCCui, `OPC_BCCso, `OPC_BALso, `OPC_MCCur
    };

    logic    iw_clk;
    logic    iw_rst;
    pc_t     pc;
    instr_t  instr;
    logic    stall;
    logic    flush;
    pc_t     pc_out;
    instr_t  instr_out;
    opc_t    opc;
    logic    sgn_en;
    logic    imm_en;
    logic    tgt_gp_we;
    logic    has_src_gp;
    logic    reads_flags;
    gp_idx_t tgt_gp;
    gp_idx_t src_gp;
    logic    has_src_ar;
    ar_idx_t src_ar;
    logic    has_tgt_ar;
    ar_idx_t tgt_ar;
    cc_t     cc;
    imm12_t  imm12;
    imm16_t  imm16;
    int      error_count;
    int      check_count;

    logic [15:0] lfsr;
    logic        drained;
    int          wait_cycles;
    int          timeout_count;

    id_stage i_id_stage (.*);

    id_checker i_checker (.*);

    initial begin
        iw_clk = 1'b0;
        forever #5 iw_clk = ~iw_clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[14:0], lfsr[0]};
        end
    endtask

    task automatic drive_random();
        logic [15:0] bits;
        logic [4:0]  idx;
        opc_t        op;
        take_bits(3, bits);
        if (bits[2:0] == 3'd0) begin
            take_bits(8, bits);
            // Low nibble 8..F is never a defined opcode
            op = {bits[7:4], 1'b1, bits[2:0]};
        end else begin
            take_bits(5, bits);
            idx = bits[4:0];
            if (idx >= 5'd19) begin
                idx = idx - 5'd19;
            end
            op = OPCODES[idx];
        end
        take_bits(16, bits);
        instr = {op, bits};
        take_bits(16, bits);
        pc = bits;
        take_bits(3, bits);
        stall = (bits[2:0] == 3'd0);
        take_bits(3, bits);
        flush = (bits[2:0] == 3'd0);
    endtask

    initial begin
        iw_rst = 1'b1;
        pc = '0;
        instr = '0;
        stall = 1'b0;
        flush = 1'b0;
        lfsr = 16'd85;
        drained = 1'b0;
        wait_cycles = 0;
        timeout_count = 0;

        repeat (10) @(posedge iw_clk);
        @(negedge iw_clk);
        iw_rst = 1'b0;
        drive_random();
        repeat (NUM_CYCLES - 1) begin
            @(negedge iw_clk);
            drive_random();
        end

        // Hold the last word until it shows up on the outputs
        @(negedge iw_clk);
        stall = 1'b0;
        flush = 1'b0;
        while (!drained && wait_cycles < DRAIN_TIMEOUT) begin
            @(negedge iw_clk);
            wait_cycles++;
            drained = (pc_out === pc) && (instr_out === instr);
        end
        if (!drained) begin
            timeout_count++;
            $display("Timeout: the last instruction never reached the stage outputs");
        end

        $display("Checks: %0d, mismatches: %0d, timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire
